/* u2_rx_pkg.sv */
/*
 * Receive core package
 * Settings bus map, readback word indexes, sample and line formats,
 * flow control limits and the framer state type
 */
package u2_rx_pkg;

   ////////////////////////////////////////
   // Settings bus
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   localparam logic [SET_ADDR_W-1:0] SR_MISC    = 8'd0;
   localparam logic [SET_ADDR_W-1:0] SR_TIME64  = 8'd10;
   localparam logic [SET_ADDR_W-1:0] SR_RX_CTRL = 8'd32;

   localparam logic [SET_ADDR_W-1:0] SR_LED_SW   = SR_MISC + 8'd3;
   localparam logic [SET_ADDR_W-1:0] SR_LED_SRC  = SR_MISC + 8'd6;
   localparam logic [SET_ADDR_W-1:0] SR_TIME_HI  = SR_TIME64 + 8'd0;
   localparam logic [SET_ADDR_W-1:0] SR_TIME_LO  = SR_TIME64 + 8'd1;
   localparam logic [SET_ADDR_W-1:0] SR_RX_CMD   = SR_RX_CTRL + 8'd0;
   localparam logic [SET_ADDR_W-1:0] SR_RX_DECIM = SR_RX_CTRL + 8'd1;
   localparam logic [SET_ADDR_W-1:0] SR_RX_CLEAR = SR_RX_CTRL + 8'd3;

   // Hardware drives bits 1 to 4 out of reset
   localparam logic [7:0] LED_SRC_RESET = 8'h1E;

   ////////////////////////////////////////
   // Readback
   localparam int RB_ADDR_W = 4;
   localparam logic [RB_ADDR_W-1:0] RB_STATUS  = 4'd8;
   localparam logic [RB_ADDR_W-1:0] RB_TIME_HI = 4'd10;
   localparam logic [RB_ADDR_W-1:0] RB_TIME_LO = 4'd11;
   localparam logic [RB_ADDR_W-1:0] RB_COMPAT  = 4'd12;
   // Major in the upper half, minor in the lower half
   localparam logic [31:0] COMPAT_NUM = {16'd8, 16'd2};

   ////////////////////////////////////////
   // Samples, lines and flow control
   localparam int ADC_W       = 14;
   localparam int SAMPLE_W    = 16;
   localparam int IQ_W        = 2 * SAMPLE_W;
   localparam int TIME_W      = 64;
   localparam int LINE_W      = 36;
   localparam int LINE_DATA_W = 32;
   localparam int NSAMPS_W    = 16;
   localparam int SEQ_W       = 16;
   localparam int DECIM_W     = 8;
   localparam int CREDIT_W    = 4;

   localparam logic [CREDIT_W-1:0] CREDIT_MAX = 4'd8;
   // Leaves room for the three header lines between strobes
   localparam logic [DECIM_W-1:0]  DECIM_MIN  = 8'd4;

   typedef enum logic [2:0] {
      FR_IDLE,
      FR_WAIT_FIRST,
      FR_HEADER,
      FR_TIME_HI,
      FR_TIME_LO,
      FR_FIRST_SAMPLE,
      FR_SAMPLES
   } framer_state_e;

endpackage

/* rx_stream_if.sv */
/*
 * Receive stream interfaces
 * rx_sample_if joins decimator and framer, rx_line_if joins
 * framer and credit sender
 */
`timescale 1ns/1ps

interface rx_sample_if;
   import u2_rx_pkg::*;

   logic              run;
   logic              strobe;
   // I in the upper half, Q in the lower half
   logic [IQ_W-1:0]   sample;
   logic [TIME_W-1:0] sample_time;

   modport decimator (
      input  run,
      output strobe,
      output sample,
      output sample_time
   );

   modport framer (
      output run,
      input  strobe,
      input  sample,
      input  sample_time
   );
endinterface

interface rx_line_if;
   import u2_rx_pkg::*;

   logic                   valid;
   logic [LINE_DATA_W-1:0] data;
   logic                   sof;
   logic                   eof;

   modport source (output valid, output data, output sof, output eof);
   modport sink   (input valid, input data, input sof, input eof);
endinterface

/* core_regs.sv */
/*
 * Core control registers
 * Decodes the misc and receive control settings, drives the LED mux
 * and returns status, time and compatibility words on readback
 */
`timescale 1ns/1ps

module core_regs (
   input  logic                              dsp_clk,
   input  logic                              arst_n_i,
   input  logic                              set_stb_i,
   input  logic [u2_rx_pkg::SET_ADDR_W-1:0]  set_addr_i,
   input  logic [u2_rx_pkg::SET_DATA_W-1:0]  set_data_i,
   input  logic                              clk_status_i,
   input  logic                              run_i,
   input  logic                              overrun_i,
   input  logic [u2_rx_pkg::TIME_W-1:0]      vita_time_i,
   input  logic [u2_rx_pkg::RB_ADDR_W-1:0]   readback_addr_i,
   output logic [31:0]                       readback_data_o,
   output logic [7:0]                        leds_o,
   output logic                              burst_start_o,
   output logic [u2_rx_pkg::NSAMPS_W-1:0]    nsamps_o,
   output logic [u2_rx_pkg::DECIM_W-1:0]     decim_o,
   output logic                              clear_o
);
   import u2_rx_pkg::*;

   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic [7:0] led_hw;

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         led_sw        <= '0;
         led_src       <= LED_SRC_RESET;
         decim_o       <= DECIM_MIN;
         nsamps_o      <= '0;
         burst_start_o <= 1'b0;
         clear_o       <= 1'b0;
      end else begin
         burst_start_o <= set_stb_i && (set_addr_i == SR_RX_CMD);
         clear_o       <= set_stb_i && (set_addr_i == SR_RX_CLEAR);
         if (set_stb_i) begin
            case (set_addr_i)
               SR_LED_SW:   led_sw   <= set_data_i[7:0];
               SR_LED_SRC:  led_src  <= set_data_i[7:0];
               SR_RX_CMD:   nsamps_o <= set_data_i[NSAMPS_W-1:0];
               SR_RX_DECIM: decim_o  <= set_data_i[DECIM_W-1:0];
               default:     ;
            endcase
         end
      end
   end

   // Hardware sources: clock status on bit 1, receive run on bit 3
   assign led_hw = {4'b0000, run_i, 1'b0, clk_status_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   ////////////////////////////////////////
   // Readback word, one cycle after address
   always_ff @(posedge dsp_clk) begin
      case (readback_addr_i)
         RB_STATUS:  readback_data_o <= {20'd0, clk_status_i, 10'd0, overrun_i};
         RB_TIME_HI: readback_data_o <= vita_time_i[63:32];
         RB_TIME_LO: readback_data_o <= vita_time_i[31:0];
         RB_COMPAT:  readback_data_o <= COMPAT_NUM;
         default:    readback_data_o <= '0;
      endcase
   end

   a_set_addr_known: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      set_stb_i |-> !$isunknown(set_addr_i));

endmodule

/* vita_timer.sv */
/*
 * VITA time counter
 * 64-bit count of sample clocks, loaded from the settings bus with a
 * staged high word so that both halves change on the same edge
 */
`timescale 1ns/1ps

module vita_timer (
   input  logic                             dsp_clk,
   input  logic                             arst_n_i,
   input  logic                             set_stb_i,
   input  logic [u2_rx_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [u2_rx_pkg::SET_DATA_W-1:0] set_data_i,
   output logic [u2_rx_pkg::TIME_W-1:0]     vita_time_o
);
   import u2_rx_pkg::*;

   logic [SET_DATA_W-1:0] time_hi_stage;

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         time_hi_stage <= '0;
         vita_time_o   <= '0;
      end else begin
         if (set_stb_i && (set_addr_i == SR_TIME_HI)) begin
            time_hi_stage <= set_data_i;
         end
         // Low word write commits the staged high word
         if (set_stb_i && (set_addr_i == SR_TIME_LO)) begin
            vita_time_o <= {time_hi_stage, set_data_i};
         end else begin
            vita_time_o <= vita_time_o + 1'b1;
         end
      end
   end

endmodule

/* rx_decimator.sv */
/*
 * Receive decimator, pipeline stage one
 * Keeps one ADC sample pair every max(decim, DECIM_MIN) cycles while
 * run is high and registers it with its time
 */
`timescale 1ns/1ps

module rx_decimator (
   input  logic                          dsp_clk,
   input  logic                          arst_n_i,
   input  logic [u2_rx_pkg::ADC_W-1:0]   adc_a_i,
   input  logic [u2_rx_pkg::ADC_W-1:0]   adc_b_i,
   input  logic [u2_rx_pkg::DECIM_W-1:0] decim_i,
   input  logic [u2_rx_pkg::TIME_W-1:0]  vita_time_i,
   rx_sample_if.decimator                smp
);
   import u2_rx_pkg::*;

   logic [DECIM_W-1:0] rate;
   logic [DECIM_W-1:0] cnt;
   logic               keep;

   assign rate = (decim_i < DECIM_MIN) ? DECIM_MIN : decim_i;
   // Counter sits at zero while stopped, so a rising run keeps at once
   assign keep = smp.run && (cnt == '0);

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt        <= '0;
         smp.strobe <= 1'b0;
      end else begin
         smp.strobe <= keep;
         if (!smp.run) begin
            cnt <= '0;
         end else if (keep) begin
            cnt <= rate - 1'b1;
         end else begin
            cnt <= cnt - 1'b1;
         end
      end
   end

   // Widen to 16 bits with two low zero bits
   always_ff @(posedge dsp_clk) begin
      if (keep) begin
         smp.sample      <= {adc_a_i, 2'b00, adc_b_i, 2'b00};
         smp.sample_time <= vita_time_i;
      end
   end

   // Minimum rate keeps strobes apart
   a_strobe_spaced: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      smp.strobe |=> !smp.strobe);

endmodule

/* rx_framer.sv */
/*
 * Receive framer, pipeline stage two
 * Turns a burst command and the kept samples into a header line,
 * two time lines and nsamps sample lines
 */
`timescale 1ns/1ps

module rx_framer (
   input  logic                           dsp_clk,
   input  logic                           arst_n_i,
   input  logic                           burst_start_i,
   input  logic [u2_rx_pkg::NSAMPS_W-1:0] nsamps_i,
   input  logic                           clear_i,
   rx_sample_if.framer                    smp,
   rx_line_if.source                      line
);
   import u2_rx_pkg::*;

   framer_state_e          state, state_nxt;
   logic [SEQ_W-1:0]       seq_num;
   logic [NSAMPS_W-1:0]    remaining;
   logic [LINE_DATA_W-1:0] hdr_word;
   logic [IQ_W-1:0]        first_sample;
   logic [TIME_W-1:0]      first_time;
   logic                   start;
   logic                   emit;
   logic                   emit_sof;
   logic                   emit_eof;
   logic [LINE_DATA_W-1:0] emit_data;
   logic                   sample_emit;

   assign start = (state == FR_IDLE) && burst_start_i && (nsamps_i != '0) && !clear_i;
   assign smp.run = (state != FR_IDLE);

   ////////////////////////////////////////
   // State names the line now on the output
   always_comb begin
      state_nxt = state;
      emit      = 1'b0;
      emit_sof  = 1'b0;
      emit_eof  = 1'b0;
      emit_data = first_sample;
      case (state)
         FR_IDLE: if (start) state_nxt = FR_WAIT_FIRST;
         FR_WAIT_FIRST: begin
            if (smp.strobe) begin
               state_nxt = FR_HEADER;
               emit      = 1'b1;
               emit_sof  = 1'b1;
               emit_data = hdr_word;
            end
         end
         FR_HEADER: begin
            state_nxt = FR_TIME_HI;
            emit      = 1'b1;
            emit_data = first_time[63:32];
         end
         FR_TIME_HI: begin
            state_nxt = FR_TIME_LO;
            emit      = 1'b1;
            emit_data = first_time[31:0];
         end
         FR_TIME_LO: begin
            state_nxt = FR_FIRST_SAMPLE;
            emit      = 1'b1;
            emit_eof  = (remaining == 16'd1);
         end
         default: begin
            if (remaining == '0) begin
               state_nxt = FR_IDLE;
            end else if (smp.strobe) begin
               state_nxt = FR_SAMPLES;
               emit      = 1'b1;
               emit_eof  = (remaining == 16'd1);
               emit_data = smp.sample;
            end
         end
      endcase
      if (clear_i) begin
         state_nxt = FR_IDLE;
         emit      = 1'b0;
      end
   end

   assign sample_emit = emit && (state_nxt inside {FR_FIRST_SAMPLE, FR_SAMPLES});

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state      <= FR_IDLE;
         seq_num    <= '0;
         remaining  <= '0;
         line.valid <= 1'b0;
      end else begin
         state      <= state_nxt;
         line.valid <= emit;
         if (start) begin
            seq_num   <= seq_num + 1'b1;
            remaining <= nsamps_i;
         end else if (sample_emit) begin
            remaining <= remaining - 1'b1;
         end
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (start) begin
         hdr_word <= {seq_num, nsamps_i};
      end
      if ((state == FR_WAIT_FIRST) && smp.strobe) begin
         first_sample <= smp.sample;
         first_time   <= smp.sample_time;
      end
      line.data <= emit_data;
      line.sof  <= emit_sof;
      line.eof  <= emit_eof;
   end

   a_no_strobe_in_header: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      (state inside {FR_HEADER, FR_TIME_HI, FR_TIME_LO}) |-> !smp.strobe);

endmodule

/* rx_credit_sender.sv */
/*
 * Receive credit sender, pipeline stage three
 * Registers lines to the output while credits remain, takes credits
 * back from the consumer and flags lines dropped at zero credit
 */
`timescale 1ns/1ps

module rx_credit_sender (
   input  logic                         dsp_clk,
   input  logic                         arst_n_i,
   input  logic                         clear_i,
   rx_line_if.sink                      line,
   input  logic                         rx_credit_i,
   output logic [u2_rx_pkg::LINE_W-1:0] rx_data_o,
   output logic                         rx_valid_o,
   output logic                         overrun_o
);
   import u2_rx_pkg::*;

   logic [CREDIT_W-1:0] credits;
   logic                send;
   logic                drop;

   assign send = line.valid && (credits != '0) && !clear_i;
   assign drop = line.valid && (credits == '0);

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         credits    <= CREDIT_MAX;
         rx_valid_o <= 1'b0;
         overrun_o  <= 1'b0;
      end else begin
         rx_valid_o <= send;
         if (clear_i) begin
            credits   <= CREDIT_MAX;
            overrun_o <= 1'b0;
         end else begin
            if (drop) begin
               overrun_o <= 1'b1;
            end
            // Send and return in one cycle cancel out
            if (send && !rx_credit_i) begin
               credits <= credits - 1'b1;
            end else if (!send && rx_credit_i && (credits != CREDIT_MAX)) begin
               credits <= credits + 1'b1;
            end
         end
      end
   end

   // Flags sit above the 32 data bits
   always_ff @(posedge dsp_clk) begin
      if (send) begin
         rx_data_o <= {2'b00, line.eof, line.sof, line.data};
      end
   end

   a_credit_not_full: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      rx_credit_i |-> (credits != CREDIT_MAX));

endmodule

/* u2_rx_core.sv */
/*
 * Receive core top level
 * Settings registers, VITA timer and the three stage receive chain
 * from the ADC inputs to the credit controlled line output
 */
`timescale 1ns/1ps

module u2_rx_core (
   input  logic                             dsp_clk,
   input  logic                             arst_n_i,
   input  logic                             set_stb_i,
   input  logic [u2_rx_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [u2_rx_pkg::SET_DATA_W-1:0] set_data_i,
   input  logic [u2_rx_pkg::ADC_W-1:0]      adc_a_i,
   input  logic [u2_rx_pkg::ADC_W-1:0]      adc_b_i,
   input  logic                             clk_status_i,
   input  logic [u2_rx_pkg::RB_ADDR_W-1:0]  readback_addr_i,
   output logic [31:0]                      readback_data_o,
   output logic [7:0]                       leds_o,
   output logic [u2_rx_pkg::LINE_W-1:0]     rx_data_o,
   output logic                             rx_valid_o,
   input  logic                             rx_credit_i,
   output logic                             overrun_o
);
   import u2_rx_pkg::*;

   logic                burst_start;
   logic [NSAMPS_W-1:0] nsamps;
   logic [DECIM_W-1:0]  decim;
   logic                clear;
   logic [TIME_W-1:0]   vita_time;

   rx_sample_if smp_if ();
   rx_line_if   line_if ();

   ////////////////////////////////////////
   // Control
   core_regs u_core_regs (
      .dsp_clk         (dsp_clk),
      .arst_n_i        (arst_n_i),
      .set_stb_i       (set_stb_i),
      .set_addr_i      (set_addr_i),
      .set_data_i      (set_data_i),
      .clk_status_i    (clk_status_i),
      .run_i           (smp_if.run),
      .overrun_i       (overrun_o),
      .vita_time_i     (vita_time),
      .readback_addr_i (readback_addr_i),
      .readback_data_o (readback_data_o),
      .leds_o          (leds_o),
      .burst_start_o   (burst_start),
      .nsamps_o        (nsamps),
      .decim_o         (decim),
      .clear_o         (clear)
   );

   vita_timer u_vita_timer (
      .dsp_clk     (dsp_clk),
      .arst_n_i    (arst_n_i),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .vita_time_o (vita_time)
   );

   ////////////////////////////////////////
   // Receive pipeline
   rx_decimator u_rx_decimator (
      .dsp_clk     (dsp_clk),
      .arst_n_i    (arst_n_i),
      .adc_a_i     (adc_a_i),
      .adc_b_i     (adc_b_i),
      .decim_i     (decim),
      .vita_time_i (vita_time),
      .smp         (smp_if.decimator)
   );

   rx_framer u_rx_framer (
      .dsp_clk       (dsp_clk),
      .arst_n_i      (arst_n_i),
      .burst_start_i (burst_start),
      .nsamps_i      (nsamps),
      .clear_i       (clear),
      .smp           (smp_if.framer),
      .line          (line_if.source)
   );

   rx_credit_sender u_rx_credit_sender (
      .dsp_clk     (dsp_clk),
      .arst_n_i    (arst_n_i),
      .clear_i     (clear),
      .line        (line_if.sink),
      .rx_credit_i (rx_credit_i),
      .rx_data_o   (rx_data_o),
      .rx_valid_o  (rx_valid_o),
      .overrun_o   (overrun_o)
   );

endmodule

/* rx_checker.sv */
/*
 * Receive line checker
 * Watches the credit sender output, rebuilds every expected line
 * from the packet rules and counts lines, packets and mismatches
 */
`timescale 1ns/1ps

module rx_checker (
   input  logic        dsp_clk,
   input  logic        rx_valid_i,
   input  logic [35:0] rx_data_i,
   input  logic [15:0] nsamps_i,
   input  logic        abort_i,
   output int          error_count_o,
   output int          line_count_o,
   output int          packet_count_o,
   output logic [15:0] last_seq_o,
   output logic [63:0] last_time_o
);

   int          errors    = 0;
   int          lines     = 0;
   int          packets   = 0;
   int          idx       = 0;
   logic        in_packet = 1'b0;
   logic [15:0] exp_seq   = 16'd0;
   logic [15:0] last_seq  = 16'd0;
   logic [63:0] cap_time  = 64'd0;
   logic [63:0] last_time = 64'd0;

   assign error_count_o  = errors;
   assign line_count_o   = lines;
   assign packet_count_o = packets;
   assign last_seq_o     = last_seq;
   assign last_time_o    = last_time;

   ////////////////////////////////////////
   // Reference model of one output line
   function automatic logic [35:0] expected_line(input logic [15:0] seq,
                                                 input logic [15:0] nsamps,
                                                 input int          line_idx,
                                                 input logic [63:0] pkt_time,
                                                 input logic [15:0] i_half);
      logic        sof;
      logic        eof;
      logic [31:0] data;
      sof = (line_idx == 0);
      eof = (line_idx == int'(nsamps) + 2);
      case (line_idx)
         0:       data = {seq, nsamps};
         1:       data = pkt_time[63:32];
         2:       data = pkt_time[31:0];
         // Q is the inverted ADC word of I, both with two zero bits
         default: data = {i_half[15:2], 2'b00, ~i_half[15:2], 2'b00};
      endcase
      return {2'b00, eof, sof, data};
   endfunction

   // Mid cycle sampling, outputs change only on the rising edge
   always @(negedge dsp_clk) begin
      logic [35:0] want;
      if (abort_i) begin
         in_packet = 1'b0;
      end
      if (rx_valid_i) begin
         lines++;
         if (rx_data_i[32]) begin
            if (in_packet) begin
               $display("%0t: header line arrived before the previous packet ended", $time);
               errors++;
            end
            in_packet = 1'b1;
            idx       = 0;
         end
         if (!in_packet) begin
            $display("%0t: line arrived outside of any packet", $time);
            errors++;
         end else begin
            if (idx == 1) begin
               cap_time[63:32] = rx_data_i[31:0];
            end
            if (idx == 2) begin
               cap_time[31:0] = rx_data_i[31:0];
            end
            want = expected_line(exp_seq, nsamps_i, idx, cap_time, rx_data_i[31:16]);
            if (rx_data_i !== want) begin
               $display("[ERROR] %0t rx_data_o: expected %h, got %h (line %0d)",
                        $time, want, rx_data_i, idx);
               errors++;
            end
            if (idx == 0) begin
               last_seq = rx_data_i[31:16];
               exp_seq++;
            end
            if (idx == 2) begin
               last_time = cap_time;
            end
            if (idx == int'(nsamps_i) + 2) begin
               in_packet = 1'b0;
               packets++;
            end
            idx++;
         end
      end
   end

endmodule

/* tb_u2_rx_core.sv */
/*
 * Receive core testbench
 * Clock, reset, LFSR driven ADC inputs, settings and readback tasks,
 * credit return and the test sequence around the DUT
 */
`timescale 1ns/1ps

module tb_u2_rx_core;

   logic        dsp_clk;
   logic        arst_n_i;
   logic        set_stb_i;
   logic [7:0]  set_addr_i;
   logic [31:0] set_data_i;
   logic [13:0] adc_a_i;
   logic [13:0] adc_b_i;
   logic        clk_status_i;
   logic [3:0]  readback_addr_i;
   logic [31:0] readback_data_o;
   logic [7:0]  leds_o;
   logic [35:0] rx_data_o;
   logic        rx_valid_o;
   logic        rx_credit_i;
   logic        overrun_o;

   logic        hold_credits;
   logic        abort;
   logic [15:0] exp_nsamps;
   logic [31:0] lfsr;
   int          fails;
   int          tests;
   int          errs_before;
   int          chk_errors;
   int          chk_lines;
   int          chk_packets;
   logic [15:0] last_seq;
   logic [63:0] last_time;

   u2_rx_core dut (.*);

   rx_checker chk (
      .dsp_clk        (dsp_clk),
      .rx_valid_i     (rx_valid_o),
      .rx_data_i      (rx_data_o),
      .nsamps_i       (exp_nsamps),
      .abort_i        (abort),
      .error_count_o  (chk_errors),
      .line_count_o   (chk_lines),
      .packet_count_o (chk_packets),
      .last_seq_o     (last_seq),
      .last_time_o    (last_time)
   );

   assign adc_b_i = ~adc_a_i;

   initial begin
      dsp_clk = 1'b0;
      forever #2 dsp_clk = ~dsp_clk;
   end

   ////////////////////////////////////////
   // Random ADC samples
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      // Taps 32, 22, 2, 1
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic take_bits(output logic [13:0] v);
      v = '0;
      for (int k = 0; k < 14; k++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[12:0], lfsr[0]};
      end
   endtask

   initial begin
      logic [13:0] a;
      adc_a_i = '0;
      lfsr    = 32'h1140d3e1;
      forever begin
         @(posedge dsp_clk);
         #1;
         take_bits(a);
         adc_a_i = a;
      end
   end

   // One credit back for every line seen
   initial begin
      rx_credit_i = 1'b0;
      forever begin
         @(posedge dsp_clk);
         #1;
         rx_credit_i = rx_valid_o && !hold_credits;
      end
   end

   ////////////////////////////////////////
   // Bus tasks
   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(posedge dsp_clk);
      #1;
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      @(posedge dsp_clk);
      #1;
      set_stb_i = 1'b0;
   endtask

   task automatic read_back(input logic [3:0] addr, output logic [31:0] data);
      @(posedge dsp_clk);
      #1;
      readback_addr_i = addr;
      @(posedge dsp_clk);
      #1;
      data = readback_data_o;
   endtask

   task automatic start_burst(input logic [15:0] n);
      exp_nsamps = n;
      write_setting(8'd32, {16'd0, n});
   endtask

   ////////////////////////////////////////
   // Checks and bounded waits
   task automatic check_value(input string name, input logic [63:0] want,
                              input logic [63:0] got);
      if (want !== got) begin
         $display("[ERROR] %0t %s: expected %h, got %h", $time, name, want, got);
         fails++;
      end
   endtask

   task automatic check_at_least(input string name, input logic [63:0] low,
                                 input logic [63:0] got);
      if (got < low) begin
         $display("[ERROR] %0t %s: expected at least %h, got %h", $time, name, low, got);
         fails++;
      end
   endtask

   task automatic wait_packets(input int target, input int limit);
      int n;
      n = 0;
      while (chk_packets < target && n < limit) begin
         @(posedge dsp_clk);
         #1;
         n++;
      end
      if (chk_packets < target) begin
         $display("%0t: no complete packet %0d within %0d cycles", $time, target, limit);
         fails++;
      end
   endtask

   task automatic wait_lines(input int target, input int limit);
      int n;
      n = 0;
      while (chk_lines < target && n < limit) begin
         @(posedge dsp_clk);
         #1;
         n++;
      end
      if (chk_lines < target) begin
         $display("%0t: only %0d of %0d lines within %0d cycles", $time, chk_lines,
                  target, limit);
         fails++;
      end
   endtask

   task automatic wait_overrun(input logic level, input int limit);
      int n;
      n = 0;
      while (overrun_o !== level && n < limit) begin
         @(posedge dsp_clk);
         #1;
         n++;
      end
      if (overrun_o !== level) begin
         $display("%0t: overrun_o did not reach %0b within %0d cycles", $time, level, limit);
         fails++;
      end
   endtask

   task automatic wait_run_led(input logic level, input int limit);
      int n;
      n = 0;
      while (leds_o[3] !== level && n < limit) begin
         @(posedge dsp_clk);
         #1;
         n++;
      end
      if (leds_o[3] !== level) begin
         $display("%0t: run LED did not reach %0b within %0d cycles", $time, level, limit);
         fails++;
      end
   endtask

   task automatic finish_test(input string name);
      int total;
      tests++;
      total = fails + chk_errors;
      $display("Test %0d %s: %s", tests, name, (total == errs_before) ? "pass" : "fail");
      errs_before = total;
   endtask

   ////////////////////////////////////////
   // Test sequence
   initial begin
      logic [31:0] rb;
      logic [63:0] t_first;
      logic [7:0]  sw_byte;
      int          l0;
      int          p0;
      arst_n_i        = 1'b0;
      set_stb_i       = 1'b0;
      set_addr_i      = '0;
      set_data_i      = '0;
      clk_status_i    = 1'b1;
      readback_addr_i = '0;
      hold_credits    = 1'b0;
      abort           = 1'b0;
      exp_nsamps      = '0;
      fails           = 0;
      tests           = 0;
      errs_before     = 0;
      repeat (16) @(posedge dsp_clk);
      #1;
      arst_n_i = 1'b1;

      @(posedge dsp_clk);
      #1;
      check_value("rx_valid_o", 64'd0, 64'(rx_valid_o));
      check_value("overrun_o", 64'd0, 64'(overrun_o));
      check_value("leds_o", 64'h02, 64'(leds_o));
      read_back(4'd12, rb);
      check_value("readback_data_o", 64'h0008_0002, 64'(rb));
      finish_test("reset state");

      write_setting(8'd33, 32'd6);
      l0 = chk_lines;
      p0 = chk_packets;
      start_burst(16'd5);
      wait_packets(p0 + 1, 400);
      repeat (20) @(posedge dsp_clk);
      check_value("line count", 64'd8, 64'(chk_lines - l0));
      check_value("header sequence", 64'd0, 64'(last_seq));
      t_first = last_time;
      finish_test("single burst");

      // Rate 2 runs at the minimum of 4
      write_setting(8'd33, 32'd2);
      p0 = chk_packets;
      start_burst(16'd4);
      wait_packets(p0 + 1, 400);
      check_value("header sequence", 64'd1, 64'(last_seq));
      check_at_least("packet time", t_first + 64'd30, last_time);
      finish_test("burst order and decimation");

      write_setting(8'd10, 32'h0000_0012);
      write_setting(8'd11, 32'h8000_0000);
      read_back(4'd10, rb);
      check_value("readback_data_o", 64'h12, 64'(rb));
      read_back(4'd11, rb);
      check_at_least("readback_data_o", 64'h8000_0000, 64'(rb));
      p0 = chk_packets;
      start_burst(16'd2);
      wait_packets(p0 + 1, 400);
      check_value("header sequence", 64'd2, 64'(last_seq));
      check_at_least("packet time", 64'h0000_0012_8000_0000, last_time);
      finish_test("time set and readback");

      hold_credits = 1'b1;
      l0 = chk_lines;
      start_burst(16'd20);
      wait_lines(l0 + 8, 400);
      wait_overrun(1'b1, 400);
      repeat (8) @(posedge dsp_clk);
      check_value("line count", 64'd8, 64'(chk_lines - l0));
      read_back(4'd8, rb);
      check_value("readback_data_o[0]", 64'd1, 64'(rb[0]));
      write_setting(8'd35, 32'd0);
      @(posedge dsp_clk);
      #1;
      abort = 1'b1;
      @(posedge dsp_clk);
      #1;
      abort        = 1'b0;
      hold_credits = 1'b0;
      wait_overrun(1'b0, 50);
      l0 = chk_lines;
      p0 = chk_packets;
      start_burst(16'd6);
      wait_packets(p0 + 1, 400);
      repeat (20) @(posedge dsp_clk);
      check_value("line count", 64'd9, 64'(chk_lines - l0));
      finish_test("credits and overrun");

      write_setting(8'd6, 32'd0);
      @(posedge dsp_clk);
      #2;
      sw_byte = adc_a_i[7:0];
      write_setting(8'd3, {24'd0, sw_byte});
      check_value("leds_o", 64'(sw_byte), 64'(leds_o));
      write_setting(8'd6, 32'h0000_00FF);
      check_value("leds_o", 64'h02, 64'(leds_o));
      p0 = chk_packets;
      start_burst(16'd3);
      wait_run_led(1'b1, 50);
      check_value("leds_o", 64'h0A, 64'(leds_o));
      wait_packets(p0 + 1, 400);
      wait_run_led(1'b0, 50);
      check_value("leds_o", 64'h02, 64'(leds_o));
      finish_test("LED mux");

      @(posedge dsp_clk);
      #1;
      $display("Tests run %0d, failed checks %0d, lines %0d, packets %0d",
               tests, fails + chk_errors, chk_lines, chk_packets);
      if (fails + chk_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* list.f */
u2_rx_pkg.sv
rx_stream_if.sv
core_regs.sv
vita_timer.sv
rx_decimator.sv
rx_framer.sv
rx_credit_sender.sv
u2_rx_core.sv
rx_checker.sv
tb_u2_rx_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the receive core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_u2_rx_core -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
   exit 0
fi
exit 1
